// File: mulDivPkg.sv
package mulDivPkg;

    localparam int XLEN = 32;
    localparam int TAG_W = 7;
    localparam int REG_NM_W = 5;
    localparam int SQN_W = 7;

    typedef logic [TAG_W-1:0] Tag;
    typedef logic [REG_NM_W-1:0] RegNm;
    typedef logic [SQN_W-1:0] SqN;

    // bit 2 selects the unit: multiplier when low, divider when high
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } MulDivOp;

    typedef struct packed {
        logic [XLEN-1:0] srcA;
        logic [XLEN-1:0] srcB;
        Tag tagDst;
        RegNm nmDst;
        SqN sqN;
        logic [XLEN-1:0] pc;
        MulDivOp opcode;
        logic valid;
    } ExUop;

    typedef struct packed {
        logic [XLEN-1:0] result;
        Tag tagDst;
        RegNm nmDst;
        SqN sqN;
        logic [XLEN-1:0] pc;
        logic valid;
    } ResUop;

    // one-cycle misprediction broadcast
    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchProv;

    function automatic logic isDivOp(MulDivOp op);
        return op[2];
    endfunction

    // sequence numbers wrap, so age comes from the signed difference
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    function automatic logic isFlushed(BranchProv br, SqN s);
        return br.taken && isYounger(s, br.sqN);
    endfunction

endpackage

// File: uopDispatch.sv
`timescale 1ns/1ps

module uopDispatch (
    input  mulDivPkg::ExUop inUop,
    input  logic mulBusy,
    input  logic divBusy,
    output logic mulEn,
    output logic divEn,
    output logic busy
);

    logic toDiv;
    logic targetBusy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // unit select and stall
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign toDiv = mulDivPkg::isDivOp(inUop.opcode);

    // only the busy level of the selected unit matters
    assign targetBusy = toDiv ? divBusy : mulBusy;

    // age is not checked here, each unit drops a flushed micro-op itself
    always_comb begin
        mulEn = 1'b0;
        divEn = 1'b0;
        if (inUop.valid && !targetBusy) begin
            if (toDiv) begin
                divEn = 1'b1;
            end else begin
                mulEn = 1'b1;
            end
        end
    end

    // the source holds its micro-op for as long as this stays high
    assign busy = inUop.valid && targetBusy;

endmodule

// File: iterMultiplier.sv
`timescale 1ns/1ps

module iterMultiplier #(
    parameter int NUM_STAGES = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  mulDivPkg::BranchProv branch,
    input  mulDivPkg::ExUop inUop,
    output logic busy,
    output mulDivPkg::ResUop outRes
);

    localparam int BITS = 32 / NUM_STAGES;
    localparam int STAGE_W = $clog2(NUM_STAGES + 1);
    localparam logic [STAGE_W-1:0] LAST_STAGE = STAGE_W'(NUM_STAGES);

    typedef struct packed {
        logic [63:0] mcand;
        logic [31:0] mplier;
        logic [63:0] acc;
        logic negate;
        logic high;
        mulDivPkg::Tag tagDst;
        mulDivPkg::RegNm nmDst;
        mulDivPkg::SqN sqN;
        logic [31:0] pc;
        logic valid;
    } MulState;

    MulState st;
    logic [STAGE_W-1:0] stage;
    logic accept;
    logic negA;
    logic negB;
    logic [31:0] magA;
    logic [31:0] magB;
    logic [63:0] partial;
    logic [63:0] product;

    // MULHSU treats only srcA as signed, MULHU neither
    always_comb begin
        negA = 1'b0;
        negB = 1'b0;
        case (inUop.opcode)
            mulDivPkg::OP_MUL, mulDivPkg::OP_MULH: begin
                negA = inUop.srcA[31];
                negB = inUop.srcB[31];
            end
            mulDivPkg::OP_MULHSU: negA = inUop.srcA[31];
            default: begin end
        endcase
        magA = negA ? -inUop.srcA : inUop.srcA;
        magB = negB ? -inUop.srcB : inUop.srcB;
    end

    assign accept = en && inUop.valid && !mulDivPkg::isFlushed(branch, inUop.sqN);

    // low in the emit cycle so the next micro-op can enter as the result leaves
    assign busy = st.valid && (stage != LAST_STAGE);

    assign partial = st.mcand * 64'(st.mplier[BITS-1:0]);
    assign product = st.negate ? -st.acc : st.acc;

    always_ff @(posedge clk) begin
        outRes.valid <= 1'b0;
        if (rst) begin
            st.valid <= 1'b0;
        end else begin
            if (st.valid) begin
                if (mulDivPkg::isFlushed(branch, st.sqN)) begin
                    st.valid <= 1'b0;
                end else if (stage != LAST_STAGE) begin
                    st.acc <= st.acc + partial;
                    st.mcand <= st.mcand << BITS;
                    st.mplier <= st.mplier >> BITS;
                    stage <= stage + 1'b1;
                end else begin
                    st.valid <= 1'b0;
                    outRes.valid <= 1'b1;
                    outRes.result <= st.high ? product[63:32] : product[31:0];
                    outRes.tagDst <= st.tagDst;
                    outRes.nmDst <= st.nmDst;
                    outRes.sqN <= st.sqN;
                    outRes.pc <= st.pc;
                end
            end
            if (accept) begin
                st.valid <= 1'b1;
                st.mcand <= {32'b0, magA};
                st.mplier <= magB;
                st.acc <= '0;
                st.negate <= negA ^ negB;
                st.high <= inUop.opcode != mulDivPkg::OP_MUL;
                st.tagDst <= inUop.tagDst;
                st.nmDst <= inUop.nmDst;
                st.sqN <= inUop.sqN;
                st.pc <= inUop.pc;
                stage <= '0;
            end
        end
    end

endmodule

// File: iterDivider.sv
`timescale 1ns/1ps

module iterDivider (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  mulDivPkg::BranchProv branch,
    input  mulDivPkg::ExUop inUop,
    output logic busy,
    output mulDivPkg::ResUop outRes
);

    localparam logic [5:0] LAST_STEP = 6'd32;

    typedef struct packed {
        logic [31:0] quo;
        logic [31:0] rem;
        logic [31:0] divisor;
        logic negQ;
        logic negR;
        logic wantRem;
        logic special;
        logic [31:0] specialVal;
        mulDivPkg::Tag tagDst;
        mulDivPkg::RegNm nmDst;
        mulDivPkg::SqN sqN;
        logic [31:0] pc;
        logic valid;
    } DivState;

    DivState st;
    logic [5:0] step;
    logic accept;
    logic signedOp;
    logic negA;
    logic negB;
    logic divZero;
    logic overflow;
    logic [31:0] specialVal;
    logic [32:0] shifted;
    logic [32:0] trial;
    logic [31:0] quotFinal;
    logic [31:0] remFinal;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // accept side decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign signedOp = !inUop.opcode[0];
    assign negA = signedOp && inUop.srcA[31];
    assign negB = signedOp && inUop.srcB[31];
    assign divZero = inUop.srcB == 32'h0;
    assign overflow = signedOp && (inUop.srcA == 32'h8000_0000) && (inUop.srcB == 32'hFFFF_FFFF);

    // RISC-V fixes these results, so they bypass the step datapath
    always_comb begin
        if (inUop.opcode[1]) begin
            specialVal = divZero ? inUop.srcA : 32'h0;
        end else begin
            specialVal = divZero ? 32'hFFFF_FFFF : 32'h8000_0000;
        end
    end

    assign accept = en && inUop.valid && !mulDivPkg::isFlushed(branch, inUop.sqN);
    assign busy = st.valid && (step != LAST_STEP);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // restoring step and sign fix-up
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // dividend bits leave the top of quo while quotient bits enter at the bottom
    assign shifted = {st.rem, st.quo[31]};
    assign trial = shifted - {1'b0, st.divisor};

    assign quotFinal = st.negQ ? -st.quo : st.quo;
    assign remFinal = st.negR ? -st.rem : st.rem;

    always_ff @(posedge clk) begin
        outRes.valid <= 1'b0;
        if (rst) begin
            st.valid <= 1'b0;
        end else begin
            if (st.valid) begin
                if (mulDivPkg::isFlushed(branch, st.sqN)) begin
                    st.valid <= 1'b0;
                end else if (step != LAST_STEP) begin
                    st.quo <= {st.quo[30:0], ~trial[32]};
                    st.rem <= trial[32] ? shifted[31:0] : trial[31:0];
                    step <= step + 6'd1;
                end else begin
                    st.valid <= 1'b0;
                    outRes.valid <= 1'b1;
                    if (st.special) begin
                        outRes.result <= st.specialVal;
                    end else begin
                        outRes.result <= st.wantRem ? remFinal : quotFinal;
                    end
                    outRes.tagDst <= st.tagDst;
                    outRes.nmDst <= st.nmDst;
                    outRes.sqN <= st.sqN;
                    outRes.pc <= st.pc;
                end
            end
            if (accept) begin
                st.valid <= 1'b1;
                st.quo <= negA ? -inUop.srcA : inUop.srcA;
                st.rem <= '0;
                st.divisor <= negB ? -inUop.srcB : inUop.srcB;
                st.negQ <= negA ^ negB;
                st.negR <= negA;
                st.wantRem <= inUop.opcode[1];
                st.special <= divZero || overflow;
                st.specialVal <= specialVal;
                st.tagDst <= inUop.tagDst;
                st.nmDst <= inUop.nmDst;
                st.sqN <= inUop.sqN;
                st.pc <= inUop.pc;
                step <= '0;
            end
        end
    end

endmodule

// File: resultMerge.sv
`timescale 1ns/1ps

module resultMerge (
    input  logic clk,
    input  logic rst,
    input  mulDivPkg::BranchProv branch,
    input  mulDivPkg::ResUop mulRes,
    input  mulDivPkg::ResUop divRes,
    output mulDivPkg::ResUop outUop
);

    mulDivPkg::ResUop held;
    logic mulOk;
    logic divOk;
    logic heldOk;

    // a completion younger than a taken branch is dropped before it can leave
    assign mulOk = mulRes.valid && !mulDivPkg::isFlushed(branch, mulRes.sqN);
    assign divOk = divRes.valid && !mulDivPkg::isFlushed(branch, divRes.sqN);
    assign heldOk = held.valid && !mulDivPkg::isFlushed(branch, held.sqN);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // priority: multiplier, held slot, divider
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        outUop.valid <= 1'b0;
        held.valid <= 1'b0;
        if (rst) begin
            outUop.valid <= 1'b0;
            held.valid <= 1'b0;
        end else begin
            if (mulOk) begin
                outUop <= mulRes;
                // the losing divider result goes out on the next cycle
                if (divOk) begin
                    held <= divRes;
                end
            end else if (heldOk) begin
                outUop <= held;
                if (divOk) begin
                    held <= divRes;
                end
            end else if (divOk) begin
                outUop <= divRes;
            end
        end
    end

endmodule

// File: mulDivCluster.sv
`timescale 1ns/1ps

module mulDivCluster #(
    parameter int NUM_STAGES = 4
) (
    input  logic clk,
    input  logic rst,
    input  mulDivPkg::ExUop inUop,
    input  mulDivPkg::BranchProv branch,
    output logic busy,
    output mulDivPkg::ResUop outUop
);

    logic mulBusy;
    logic divBusy;
    logic mulEn;
    logic divEn;
    mulDivPkg::ResUop mulRes;
    mulDivPkg::ResUop divRes;

    uopDispatch dispatch (
        .inUop   (inUop),
        .mulBusy (mulBusy),
        .divBusy (divBusy),
        .mulEn   (mulEn),
        .divEn   (divEn),
        .busy    (busy)
    );

    iterMultiplier #(
        .NUM_STAGES (NUM_STAGES)
    ) mul (
        .clk    (clk),
        .rst    (rst),
        .en     (mulEn),
        .branch (branch),
        .inUop  (inUop),
        .busy   (mulBusy),
        .outRes (mulRes)
    );

    iterDivider div (
        .clk    (clk),
        .rst    (rst),
        .en     (divEn),
        .branch (branch),
        .inUop  (inUop),
        .busy   (divBusy),
        .outRes (divRes)
    );

    resultMerge merge (
        .clk    (clk),
        .rst    (rst),
        .branch (branch),
        .mulRes (mulRes),
        .divRes (divRes),
        .outUop (outUop)
    );

endmodule

// File: mulDivCluster_chk.sv
`timescale 1ns/1ps

module mulDivClusterChk (
    input logic clk,
    input logic rst,
    input mulDivPkg::ExUop inUop,
    input logic busy,
    input mulDivPkg::ResUop outUop
);

    // nothing is in flight right after reset
    assert property (@(posedge clk) rst |=> !busy && !outUop.valid)
        else $error("busy or outUop.valid high after reset");

    // a stalled micro-op is held by its source
    assert property (@(posedge clk) disable iff (rst) inUop.valid && busy |=> $stable(inUop))
        else $error("inUop changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        outUop.valid |=> !(outUop.valid && outUop.tagDst == $past(outUop.tagDst)))
        else $error("same tag reported on two consecutive cycles");

endmodule

bind mulDivCluster mulDivClusterChk chk (
    .clk    (clk),
    .rst    (rst),
    .inUop  (inUop),
    .busy   (busy),
    .outUop (outUop)
);

// File: mulDivClusterTb.sv
`timescale 1ns/1ps

module mulDivClusterTb;

    localparam int NUM_STAGES = 4;

    logic clk = 1'b0;
    logic rst;
    mulDivPkg::ExUop inUop;
    mulDivPkg::BranchProv branch;
    logic busy;
    mulDivPkg::ResUop outUop;
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int seed = 77253;
    logic [6:0] nextTag = '0;
    logic [6:0] monTag;
    logic [31:0] expVal [128];
    int expCycle [128];
    bit outstanding [128];
    logic [31:0] corners [5] = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};

    mulDivCluster #(.NUM_STAGES(NUM_STAGES)) UUT (
        .clk(clk), .rst(rst), .inUop(inUop), .branch(branch), .busy(busy), .outUop(outUop)
    );

    always #50 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    // the RISC-V M extension rules, worked out in 64 bits
    function automatic logic [31:0] refModel(logic [2:0] op, logic [31:0] a, logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        sq = '0;
        sr = '0;
        if (b != 32'h0) begin
            sq = $signed(sa) / $signed(sb);
            sr = $signed(sa) % $signed(sb);
        end
        case (op)
            3'd0: return 32'(sa * sb);
            3'd1: return 32'((sa * sb) >> 32);
            3'd2: return 32'((sa * ub) >> 32);
            3'd3: return 32'((ua * ub) >> 32);
            3'd4: return (b == 0) ? 32'hFFFF_FFFF :
                (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) ? a : sq[31:0];
            3'd5: return (b == 0) ? 32'hFFFF_FFFF : a / b;
            3'd6: return (b == 0) ? a :
                (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) ? 32'h0 : sr[31:0];
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    // called at a falling edge and returns at the falling edge after the accept edge
    task automatic issueUop(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                            input int late, input bit wanted, input bit flushNow);
        logic [6:0] t;
        int n;
        t = nextTag;
        nextTag = nextTag + 1'b1;
        inUop = '{srcA: a, srcB: b, tagDst: t, nmDst: t[4:0], sqN: t,
                  pc: 32'h1000 + {t, 2'b00}, opcode: mulDivPkg::MulDivOp'(op), valid: 1'b1};
        if (flushNow) begin
            branch = '{taken: 1'b1, sqN: t - 7'd1};
        end
        #1;
        n = 0;
        while (busy && n < 100) begin
            @(negedge clk);
            #1;
            n++;
        end
        assert (!busy) else begin
            $display("timeout: busy never dropped for tag %h", t);
            errors++;
        end
        if (wanted) begin
            expVal[t] = refModel(op, a, b);
            expCycle[t] = cycle + 1 + (op[2] ? 34 : NUM_STAGES + 2) + late;
            outstanding[t] = 1'b1;
        end
        @(posedge clk);
        @(negedge clk);
        inUop.valid = 1'b0;
        branch.taken = 1'b0;
    endtask

    task automatic waitDone(input logic [6:0] t);
        int n;
        n = 0;
        while (outstanding[t] && n < 60) begin
            @(negedge clk);
            n++;
        end
        assert (!outstanding[t]) else begin
            $display("timeout: no result for tag %h", t);
            errors++;
            outstanding[t] = 1'b0;
        end
    endtask

    task automatic runOne(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b);
        issueUop(op, a, b, 0, 1'b1, 1'b0);
        waitDone(nextTag - 7'd1);
    endtask

    task automatic arithSweep(input bit divide);
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    runOne({divide, op[1:0]}, corners[i], corners[j]);
                end
            end
            for (int k = 0; k < 8; k++) begin
                runOne({divide, op[1:0]}, $random(seed), $random(seed));
            end
        end
    endtask

    task automatic backToBack();
        logic [6:0] first;
        int gap;
        first = nextTag;
        for (int k = 0; k < 3; k++) issueUop(3'd1, $random(seed), $random(seed), 0, 1'b1, 1'b0);
        for (int k = 0; k < 2; k++) issueUop(3'd4, $random(seed), $random(seed), 0, 1'b1, 1'b0);
        // a waiting micro-op enters on the edge where the one ahead of it leaves the unit
        for (int k = 0; k < 4; k++) begin
            if (k != 2) begin
                gap = expCycle[first + 7'(k + 1)] - expCycle[first + 7'(k)];
                assert (gap == ((k < 2) ? NUM_STAGES + 1 : 33)) else begin
                    $display("FAILED busy: expected issue gap %h got %h",
                             (k < 2) ? NUM_STAGES + 1 : 33, gap);
                    errors++;
                end
            end
        end
        for (int k = 0; k < 5; k++) waitDone(first + 7'(k));
    endtask

    task automatic collideUnits();
        issueUop(3'd6, $random(seed), 32'h13, 1, 1'b1, 1'b0);
        repeat (27) @(negedge clk);
        issueUop(3'd0, $random(seed), $random(seed), 0, 1'b1, 1'b0);
        waitDone(nextTag - 7'd2);
        waitDone(nextTag - 7'd1);
    endtask

    // the branch carries the older micro-op's sqN, so the younger one dies
    task automatic flushInFlight(input bit divFirst);
        logic [6:0] older;
        older = nextTag;
        issueUop(divFirst ? 3'd5 : 3'd3, $random(seed), 32'h7, 0, 1'b1, 1'b0);
        issueUop(divFirst ? 3'd2 : 3'd7, $random(seed), 32'h9, 0, 1'b0, 1'b0);
        branch = '{taken: 1'b1, sqN: older};
        @(negedge clk);
        branch.taken = 1'b0;
        waitDone(older);
        repeat (40) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (!rst && outUop.valid) begin
            monTag = outUop.tagDst;
            checks++;
            assert (outstanding[monTag]) else begin
                $display("unexpected or duplicate result for tag %h", monTag);
                errors++;
            end
            if (outstanding[monTag]) begin
                outstanding[monTag] = 1'b0;
                assert (outUop.result == expVal[monTag]) else begin
                    $display("FAILED outUop.result tag %h: expected %h got %h",
                             monTag, expVal[monTag], outUop.result);
                    errors++;
                end
                assert (outUop.nmDst == monTag[4:0]) else begin
                    $display("FAILED outUop.nmDst tag %h: expected %h got %h",
                             monTag, monTag[4:0], outUop.nmDst);
                    errors++;
                end
                assert (outUop.sqN == monTag) else begin
                    $display("FAILED outUop.sqN tag %h: expected %h got %h",
                             monTag, monTag, outUop.sqN);
                    errors++;
                end
                assert (outUop.pc == 32'h1000 + {monTag, 2'b00}) else begin
                    $display("FAILED outUop.pc tag %h: expected %h got %h",
                             monTag, 32'h1000 + {monTag, 2'b00}, outUop.pc);
                    errors++;
                end
                assert (cycle == expCycle[monTag]) else begin
                    $display("FAILED outUop.valid cycle tag %h: expected %h got %h",
                             monTag, expCycle[monTag], cycle);
                    errors++;
                end
            end
        end
    end

    initial begin
        #2000000;
        $display("timeout: simulation ran too long");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        inUop = '0;
        branch = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        arithSweep(1'b0);
        arithSweep(1'b1);
        backToBack();
        collideUnits();
        flushInFlight(1'b1);
        flushInFlight(1'b0);
        // a micro-op on the flush edge itself is never captured
        issueUop(3'd0, 32'h5, 32'h6, 0, 1'b0, 1'b1);
        repeat (10) @(negedge clk);
        $display("errors: %0d, results checked: %0d", errors, checks);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: mulDivCluster.f
mulDivPkg.sv
uopDispatch.sv
iterMultiplier.sv
iterDivider.sv
resultMerge.sv
mulDivCluster.sv
mulDivCluster_chk.sv
mulDivClusterTb.sv

// File: Makefile
TOP = mulDivClusterTb

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal -f mulDivCluster.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee run.log
	@grep -q "TEST OK" run.log

clean:
	rm -rf obj_dir run.log
